// File: logic/fsk_defines.svh
`ifndef FSK_DEFINES_SVH
`define FSK_DEFINES_SVH

// ==============================
// datapath widths
// ==============================
`define FSK_PHASE_BITS      8
`define FSK_SAMPLE_BITS     8
`define FSK_ACC_BITS        24   // 256 products of 8 x 8 bits

// ==============================
// tones and reference table
// ==============================
`define FSK_TONE_COUNT      2
`define FSK_QUARTER_ENTRIES 64
`define FSK_MARK_HARMONIC   1    // cycles per window
`define FSK_SPACE_HARMONIC  2

`endif

// File: logic/fsk_sample_pkg.sv
`include "fsk_defines.svh"

package fsk_sample_pkg;

    // position of a sample within its window
    typedef logic [`FSK_PHASE_BITS-1:0] phase_t;

    typedef logic signed [`FSK_SAMPLE_BITS-1:0] sample_t;
    typedef logic signed [`FSK_SAMPLE_BITS-1:0] ref_t;

    // input beat
    typedef struct packed {
        phase_t  phase;
        sample_t sample;
    } sample_beat_t;

    // sample paired with its reference values, tone 0 is mark
    typedef struct packed {
        sample_t                     sample;
        ref_t [`FSK_TONE_COUNT-1:0]  refs;
        logic                        last;   // phase was 255
    } ref_beat_t;

endpackage

// File: logic/fsk_symbol_pkg.sv
`include "fsk_defines.svh"

package fsk_symbol_pkg;

    // window correlation
    typedef logic signed [`FSK_ACC_BITS-1:0] corr_t;

    // one correlation per tone, index 0 is mark
    typedef corr_t [`FSK_TONE_COUNT-1:0] corr_result_t;

    typedef enum logic {
        SPACE = 1'b0,
        MARK  = 1'b1
    } symbol_t;

endpackage

// File: logic/tone_ref_lookup.sv
`include "fsk_defines.svh"

module tone_ref_lookup
    import fsk_sample_pkg::*;
(
    input  logic         sys_clk,
    input  logic         rst_n,
    input  sample_beat_t sample_in,
    input  logic         sample_valid,
    output logic         sample_ready,
    output ref_beat_t    ref_beat,
    output logic         ref_valid,
    input  logic         ref_ready
);

    localparam int QTR_BITS = $clog2(`FSK_QUARTER_ENTRIES);
    localparam int MAG_BITS = `FSK_SAMPLE_BITS - 1;
    localparam logic [MAG_BITS-1:0] PEAK = '1;   // 127
    localparam int TONE_HARMONIC [`FSK_TONE_COUNT] = '{`FSK_MARK_HARMONIC,
                                                       `FSK_SPACE_HARMONIC};

    ref_beat_t next_beat;
    logic      accept;

    // ==============================
    // quarter-wave sine, 127 * sin
    // ==============================
    function automatic logic [MAG_BITS-1:0] quarter_sine(input logic [QTR_BITS-1:0] idx);
        logic [MAG_BITS-1:0] mag;
        case (idx)
            6'd0:  mag = 7'd0;
            6'd1:  mag = 7'd3;
            6'd2:  mag = 7'd6;
            6'd3:  mag = 7'd9;
            6'd4:  mag = 7'd12;
            6'd5:  mag = 7'd16;
            6'd6:  mag = 7'd19;
            6'd7:  mag = 7'd22;
            6'd8:  mag = 7'd25;
            6'd9:  mag = 7'd28;
            6'd10: mag = 7'd31;
            6'd11: mag = 7'd34;
            6'd12: mag = 7'd37;
            6'd13: mag = 7'd40;
            6'd14: mag = 7'd43;
            6'd15: mag = 7'd46;
            6'd16: mag = 7'd49;
            6'd17: mag = 7'd51;
            6'd18: mag = 7'd54;
            6'd19: mag = 7'd57;
            6'd20: mag = 7'd60;
            6'd21: mag = 7'd63;
            6'd22: mag = 7'd65;
            6'd23: mag = 7'd68;
            6'd24: mag = 7'd71;
            6'd25: mag = 7'd73;
            6'd26: mag = 7'd76;
            6'd27: mag = 7'd78;
            6'd28: mag = 7'd81;
            6'd29: mag = 7'd83;
            6'd30: mag = 7'd85;
            6'd31: mag = 7'd88;
            6'd32: mag = 7'd90;
            6'd33: mag = 7'd92;
            6'd34: mag = 7'd94;
            6'd35: mag = 7'd96;
            6'd36: mag = 7'd98;
            6'd37: mag = 7'd100;
            6'd38: mag = 7'd102;
            6'd39: mag = 7'd104;
            6'd40: mag = 7'd106;
            6'd41: mag = 7'd107;
            6'd42: mag = 7'd109;
            6'd43: mag = 7'd111;
            6'd44: mag = 7'd112;
            6'd45: mag = 7'd113;
            6'd46: mag = 7'd115;
            6'd47: mag = 7'd116;
            6'd48: mag = 7'd117;
            6'd49: mag = 7'd118;
            6'd50: mag = 7'd120;
            6'd51: mag = 7'd121;
            6'd52: mag = 7'd122;
            6'd53: mag = 7'd122;
            6'd54: mag = 7'd123;
            6'd55: mag = 7'd124;
            6'd56: mag = 7'd125;
            6'd57: mag = 7'd125;
            6'd58: mag = 7'd126;
            6'd59: mag = 7'd126;
            6'd60: mag = 7'd126;
            6'd61: mag = 7'd127;
            6'd62: mag = 7'd127;
            default: mag = 7'd127;   // idx 63
        endcase
        return mag;
    endfunction

    // full-wave value from the quadrant bits
    function automatic ref_t sine_lookup(input phase_t p);
        logic [QTR_BITS-1:0] idx;
        logic [QTR_BITS:0]   mirror;
        logic [MAG_BITS-1:0] mag;
        idx    = p[QTR_BITS-1:0];
        mirror = (QTR_BITS+1)'(`FSK_QUARTER_ENTRIES) - {1'b0, idx};
        if (!p[QTR_BITS]) begin
            mag = quarter_sine(idx);            // rising quarter
        end else if (mirror[QTR_BITS]) begin
            mag = PEAK;                          // exactly at the crest
        end else begin
            mag = quarter_sine(mirror[QTR_BITS-1:0]);
        end
        // second half of the cycle is negative
        return p[`FSK_PHASE_BITS-1] ? -ref_t'({1'b0, mag}) : ref_t'({1'b0, mag});
    endfunction

    // ==============================
    // beat register
    // ==============================
    always_comb begin
        next_beat.sample = sample_in.sample;
        next_beat.last   = (sample_in.phase == '1);
        for (int t = 0; t < `FSK_TONE_COUNT; t++) begin
            // harmonic h reads the table at h * phase, wrapping per cycle
            next_beat.refs[t] = sine_lookup(phase_t'(sample_in.phase * TONE_HARMONIC[t]));
        end
    end

    assign sample_ready = !ref_valid || ref_ready;
    assign accept       = sample_valid && sample_ready;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_valid <= 1'b0;
        end else if (sample_ready) begin
            ref_valid <= sample_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (accept) begin
            ref_beat <= next_beat;
        end
    end

endmodule

// File: logic/tone_correlator.sv
`include "fsk_defines.svh"

module tone_correlator
    import fsk_sample_pkg::*;
    import fsk_symbol_pkg::*;
#(
    parameter int HARMONIC_IDX = 0   // which refs field to use
) (
    input  logic      sys_clk,
    input  logic      rst_n,
    input  ref_beat_t ref_beat,
    input  logic      ref_valid,
    output logic      ready,
    output corr_t     corr,
    output logic      result_valid,
    input  logic      result_ready
);

    logic signed [2*`FSK_SAMPLE_BITS-1:0] product;
    corr_t                                acc;
    corr_t                                acc_next;
    logic                                 take_beat;
    logic                                 window_end;

    // a last beat has to wait for the result register to drain
    assign ready      = !(ref_beat.last && result_valid);
    assign take_beat  = ref_valid && ready;
    assign window_end = take_beat && ref_beat.last;

    assign product  = $signed(ref_beat.sample) * $signed(ref_beat.refs[HARMONIC_IDX]);
    assign acc_next = acc + product;   // sign extended to acc width

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            acc          <= '0;
            result_valid <= 1'b0;
        end else begin
            if (take_beat) begin
                acc <= ref_beat.last ? '0 : acc_next;   // restart per window
            end
            if (window_end) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    // window total, includes the last product
    always_ff @(posedge sys_clk) begin
        if (window_end) begin
            corr <= acc_next;
        end
    end

endmodule

// File: logic/symbol_decider.sv
module symbol_decider
    import fsk_symbol_pkg::*;
(
    input  logic         sys_clk,
    input  logic         rst_n,
    input  corr_result_t corr_in,
    input  logic         result_valid,
    output logic         result_ready,
    output symbol_t      symbol,
    output logic         symbol_valid,
    input  logic         symbol_ready
);

    symbol_t decision;
    logic    take;

    // tone 0 is mark, tone 1 is space; a tie goes to space
    assign decision = ($signed(corr_in[0]) > $signed(corr_in[1])) ? MARK : SPACE;

    assign result_ready = !symbol_valid || symbol_ready;
    assign take         = result_valid && result_ready;

    // ==============================
    // output symbol register
    // ==============================
    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            symbol_valid <= 1'b0;
        end else if (result_ready) begin
            symbol_valid <= result_valid;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (take) begin
            symbol <= decision;   // held until symbol_ready
        end
    end

endmodule

// File: logic/fsk_demod.sv
`include "fsk_defines.svh"

module fsk_demod
    import fsk_sample_pkg::*;
    import fsk_symbol_pkg::*;
(
    input  logic         sys_clk,
    input  logic         rst_n,
    input  sample_beat_t sample_in,
    input  logic         sample_valid,
    output logic         sample_ready,
    output symbol_t      symbol,
    output logic         symbol_valid,
    input  logic         symbol_ready
);

    ref_beat_t                  ref_beat;
    logic                       ref_valid;
    logic                       ref_ready;
    logic [`FSK_TONE_COUNT-1:0] tone_ready;
    logic [`FSK_TONE_COUNT-1:0] tone_valid;
    corr_result_t               corr_all;
    logic                       result_ready;

    tone_ref_lookup u_lookup (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .ref_beat     (ref_beat),
        .ref_valid    (ref_valid),
        .ref_ready    (ref_ready)
    );

    assign ref_ready = &tone_ready;

    // one correlator per tone, all step together
    for (genvar i = 0; i < `FSK_TONE_COUNT; i++) begin : g_tone
        tone_correlator #(
            .HARMONIC_IDX (i)
        ) u_corr (
            .sys_clk      (sys_clk),
            .rst_n        (rst_n),
            .ref_beat     (ref_beat),
            .ref_valid    (ref_valid),
            .ready        (tone_ready[i]),
            .corr         (corr_all[i]),
            .result_valid (tone_valid[i]),
            .result_ready (result_ready)
        );
    end

    symbol_decider u_decider (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .corr_in      (corr_all),
        .result_valid (tone_valid[0]),   // lock step, tone 0 speaks for all
        .result_ready (result_ready),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .symbol_ready (symbol_ready)
    );

endmodule

// File: verif/tb_clk_gen.sv
module tb_clk_gen #(
    parameter int PERIOD = 20
) (
    output logic sys_clk
);

    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD / 2) sys_clk = ~sys_clk;
    end

endmodule

// File: verif/fsk_demod_props.sv
module fsk_demod_props
    import fsk_sample_pkg::*;
    import fsk_symbol_pkg::*;
(
    input logic         sys_clk,
    input logic         rst_n,
    input sample_beat_t sample_in,
    input logic         sample_valid,
    input logic         sample_ready,
    input symbol_t      symbol,
    input logic         symbol_valid,
    input logic         symbol_ready
);

    int failures = 0;   // assertion failures so far

    // output channel holds its beat while stalled
    property symbol_held;
        @(posedge sys_clk) disable iff (!rst_n)
        (symbol_valid && !symbol_ready) |=> (symbol_valid && $stable(symbol));
    endproperty

    property sample_held;
        @(posedge sys_clk) disable iff (!rst_n)
        (sample_valid && !sample_ready) |=> (sample_valid && $stable(sample_in));
    endproperty

    a_symbol_held: assert property (symbol_held)
        else begin
            failures++;
            $error("symbol changed while stalled");
        end
    a_sample_held: assert property (sample_held)
        else begin
            failures++;
            $error("sample_in changed while stalled");
        end
    a_reset_quiet: assert property (@(posedge sys_clk) !rst_n |-> !symbol_valid)
        else begin
            failures++;
            $error("symbol_valid high during reset");
        end

endmodule

// File: verif/tb_fsk_demod.sv
module tb_fsk_demod
    import fsk_sample_pkg::*;
    import fsk_symbol_pkg::*;
();

    localparam int WINDOW_LEN  = 256;
    localparam int WAIT_LIMIT  = 4000;   // cycles per wait loop
    localparam int KIND_ZERO   = 0;
    localparam int KIND_MARK   = 1;
    localparam int KIND_SPACE  = 2;
    localparam int KIND_INVERT = 3;      // one-cycle tone, negated
    localparam real PI = 3.14159265358979;

    logic         sys_clk;
    logic         rst_n;
    sample_beat_t sample_in;
    logic         sample_valid;
    logic         sample_ready;
    symbol_t      symbol;
    logic         symbol_valid;
    logic         symbol_ready;

    integer  seed;
    logic    ready_hold;
    logic    gaps_on;
    logic    timed_out;
    int      mismatch_count;
    int      timeout_count;
    symbol_t exp_q[$];
    symbol_t got_q[$];

    tb_clk_gen #(.PERIOD(20)) u_clk (.sys_clk(sys_clk));

    fsk_demod DUT (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .symbol_ready (symbol_ready)
    );

    bind fsk_demod fsk_demod_props u_props (
        .sys_clk      (sys_clk),
        .rst_n        (rst_n),
        .sample_in    (sample_in),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .symbol       (symbol),
        .symbol_valid (symbol_valid),
        .symbol_ready (symbol_ready)
    );

    // output monitor
    always @(posedge sys_clk) begin
        if (rst_n && symbol_valid && symbol_ready) begin
            got_q.push_back(symbol);
        end
    end

    // ==============================
    // stimulus helpers
    // ==============================
    function automatic sample_t tone_sample(input int kind, input int p);
        real amp;
        real cycles;
        amp    = (kind == KIND_INVERT) ? -100.0 : 100.0;
        cycles = (kind == KIND_SPACE) ? 2.0 : 1.0;
        if (kind == KIND_ZERO) begin
            return '0;
        end
        return sample_t'(int'(amp * $sin(2.0 * PI * cycles * p / WINDOW_LEN)));
    endfunction

    // only a one-cycle tone wins strictly, ties and negative mark go to space
    function automatic symbol_t expected_symbol(input int kind);
        return (kind == KIND_MARK) ? MARK : SPACE;
    endfunction

    task automatic apply_ready();
        if (ready_hold) begin
            symbol_ready = 1'b0;
        end else if (gaps_on) begin
            symbol_ready = (($random(seed) & 3) != 0);
        end else begin
            symbol_ready = 1'b1;
        end
    endtask

    task automatic next_cycle();
        @(negedge sys_clk);
        apply_ready();
    endtask

    task automatic send_sample(input int p, input sample_t s);
        int  cycles;
        int  gap;
        logic accepted;
        cycles   = 0;
        accepted = 1'b0;
        if (gaps_on) begin
            gap = (($random(seed) & 7) < 2) ? ($random(seed) & 3) : 0;
            repeat (gap) next_cycle();
        end
        sample_in.phase  = phase_t'(p);
        sample_in.sample = s;
        sample_valid     = 1'b1;
        while (!accepted && cycles < WAIT_LIMIT && !timed_out) begin
            @(posedge sys_clk);
            accepted = sample_ready;
            next_cycle();
            cycles++;
        end
        sample_valid = 1'b0;
        if (!accepted && !timed_out) begin
            timed_out = 1'b1;
            timeout_count++;
            $display("timeout: sample at phase %0d was never accepted", p);
        end
    endtask

    task automatic send_window(input int kind);
        exp_q.push_back(expected_symbol(kind));
        for (int p = 0; p < WINDOW_LEN; p++) begin
            send_sample(p, tone_sample(kind, p));
        end
    endtask

    task automatic wait_symbols(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n && cycles < WAIT_LIMIT && !timed_out) begin
            next_cycle();
            cycles++;
        end
        if (got_q.size() < n && !timed_out) begin
            timed_out = 1'b1;
            timeout_count++;
            $display("timeout: only %0d of %0d symbols arrived", got_q.size(), n);
        end
    endtask

    // ==============================
    // compare tasks
    // ==============================
    task automatic compare_symbol(input int idx, input symbol_t exp, input symbol_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch symbol[%0d]: expected %h, actual %h", idx, exp, act);
        end
    endtask

    task automatic compare_count(input int exp, input int act);
        if (act != exp) begin
            mismatch_count++;
            $display("Mismatch symbol count: expected %h, actual %h", exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            mismatch_count++;
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_symbols();
        compare_count(exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            compare_symbol(i, exp_q[i], got_q[i]);
        end
        exp_q.delete();
        got_q.delete();
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_reset_state();
        compare_flag("symbol_valid", 1'b0, symbol_valid);
        compare_flag("sample_ready", 1'b1, sample_ready);
    endtask

    task automatic test_single(input int kind);
        send_window(kind);
        wait_symbols(1);
        repeat (4) next_cycle();
        check_symbols();
    endtask

    task automatic test_backpressure();
        ready_hold = 1'b1;
        apply_ready();
        send_window(KIND_MARK);
        send_window(KIND_SPACE);
        send_window(KIND_MARK);
        repeat (8) next_cycle();
        compare_count(0, got_q.size());   // nothing leaks while stalled
        compare_flag("sample_ready", 1'b0, sample_ready);   // third last beat is stuck
        ready_hold = 1'b0;
        apply_ready();
        wait_symbols(3);
        repeat (8) next_cycle();
        check_symbols();
    endtask

    task automatic test_random_gaps();
        gaps_on = 1'b1;
        send_window(KIND_MARK);
        send_window(KIND_SPACE);
        send_window(KIND_MARK);
        send_window(KIND_MARK);
        send_window(KIND_SPACE);
        wait_symbols(5);
        gaps_on = 1'b0;
        repeat (8) next_cycle();
        check_symbols();
    endtask

    initial begin
        seed           = 32'h3575;
        rst_n          = 1'b0;
        sample_in      = '0;
        sample_valid   = 1'b0;
        symbol_ready   = 1'b1;
        ready_hold     = 1'b0;
        gaps_on        = 1'b0;
        timed_out      = 1'b0;
        mismatch_count = 0;
        timeout_count  = 0;

        repeat (3) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        test_reset_state();
        test_single(KIND_MARK);
        test_single(KIND_SPACE);
        test_single(KIND_ZERO);
        test_single(KIND_INVERT);
        test_backpressure();
        test_random_gaps();

        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatch_count, timeout_count, DUT.u_props.failures);
        if (mismatch_count == 0 && timeout_count == 0 && DUT.u_props.failures == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: fsk_demod.f
+incdir+logic
logic/fsk_sample_pkg.sv
logic/fsk_symbol_pkg.sv
logic/tone_ref_lookup.sv
logic/tone_correlator.sv
logic/symbol_decider.sv
logic/fsk_demod.sv
verif/tb_clk_gen.sv
verif/fsk_demod_props.sv
verif/tb_fsk_demod.sv

// File: Bender.yml
package:
  name: fsk_demod

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fsk_sample_pkg.sv
      - logic/fsk_symbol_pkg.sv
      - logic/tone_ref_lookup.sv
      - logic/tone_correlator.sv
      - logic/symbol_decider.sv
      - logic/fsk_demod.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/fsk_demod_props.sv
      - verif/tb_fsk_demod.sv
